// ==== list.f ====
+incdir+.
graph_pkg.sv
mem_pkg.sv
vertex_control_fsm.sv
edge_counter.sv
read_command_gen.sv
rank_sum_accum.sv
pagerank_cu_top.sv
tb_pagerank_cu_asserts.sv
tb_pagerank_cu.sv

// ==== Makefile ====
# Verilator build and run of the PageRank compute unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pagerank_cu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_pagerank_cu.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the PageRank vertex compute unit
// Directed vertex jobs against a delaying, reordering memory model
//////////////////////////////////////////////////////////////////////

module tb_pagerank_cu import graph_pkg::*, mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Edges over all tests: 5, 0, 12, 4 and the sequence 3+0+6+2
	localparam int total_edges     = 5 + 0 + 12 + 4 + 11;
	localparam int watchdog_cycles = total_edges * 40;

	logic        clock;
	logic        rstn;
	logic        job_req;
	vertex_job_t job;
	logic        job_ack;
	read_cmd_t   read_cmd;
	logic        read_stall = 1'b0;
	read_rsp_t   read_rsp = '0;
	logic        write_req;
	write_cmd_t  write_cmd;
	logic        write_ack;
	edge_count_t vertex_count;
	edge_count_t edge_count;

	// Memory model controls and command log
	bit          random_stall;
	bit          reorder;
	bit          inject_bad;
	int          max_delay;
	int          cycle;
	mem_addr_t   pending_addr[$];
	int          pending_due[$];
	mem_addr_t   cmd_addr[$];
	struct_tag_t cmd_tag[$];

	int          error_count;
	int          writes_done;
	int          ack_count;
	logic        ack_prev = 1'b0;
	edge_count_t exp_vertices;
	edge_count_t exp_edges;

	pagerank_cu_top pagerank_cu_top_inst (.*);

	bind pagerank_cu_top tb_pagerank_cu_asserts asserts_inst (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Stored rank of each address
	function automatic rank_t model_rank(input mem_addr_t addr);
		return rank_t'(addr) * rank_t'(3) + rank_t'(1);
	endfunction

	function automatic rank_t expected_sum(input vertex_job_t j);
		rank_t sum;
		sum = '0;
		for (int i = 0; i < j.degree; i++) begin
			sum = sum + model_rank(mem_addr_t'(j.base) + mem_addr_t'(i));
		end
		return sum;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		error_count++;
		$display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory responder and intake monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin : responder
		int ready[$];
		int pick;
		cycle++;
		if (read_cmd.valid) begin
			cmd_addr.push_back(read_cmd.addr);
			cmd_tag.push_back(read_cmd.tag);
			pending_addr.push_back(read_cmd.addr);
			pending_due.push_back(cycle + 1 + $urandom_range(max_delay, 0));
		end
		ready.delete();
		foreach (pending_due[i]) begin
			if (pending_due[i] <= cycle) begin
				ready.push_back(i);
			end
		end
		read_rsp = '0;
		if (inject_bad && ($urandom_range(3, 0) == 0)) begin
			// Foreign structure traffic on the response port
			read_rsp.valid = 1'b1;
			read_rsp.tag   = ($urandom_range(1, 0) == 0) ? tag_edge_array : tag_other;
			read_rsp.data  = $urandom | 32'h1;
		end else if (ready.size() > 0) begin
			pick = reorder ? ready[$urandom_range(ready.size() - 1, 0)] : ready[0];
			read_rsp.valid = 1'b1;
			read_rsp.tag   = tag_graph_data;
			read_rsp.data  = model_rank(pending_addr[pick]);
			pending_addr.delete(pick);
			pending_due.delete(pick);
		end
		read_stall = random_stall && ($urandom_range(2, 0) == 0);
	end

	// Every job_ack must come after all earlier writes finished
	always @(negedge clock) begin
		if (rstn && job_ack && !ack_prev) begin
			if (ack_count != writes_done) begin
				error_count++;
				$display("error at %0t: job_ack %0d came with %0d writes finished",
					$time, ack_count + 1, writes_done);
			end
			ack_count++;
		end
		ack_prev = job_ack;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake tasks and checks
	//////////////////////////////////////////////////////////////////////

	task automatic send_job(input vertex_job_t j);
		@(negedge clock);
		job     = j;
		job_req = 1'b1;
		do @(negedge clock); while (!job_ack);
		job_req = 1'b0;
		do @(negedge clock); while (job_ack);
	endtask

	// Totals are visible on return
	task automatic collect_write(input int ack_delay, output write_cmd_t got);
		do @(negedge clock); while (!write_req);
		got = write_cmd;
		repeat (ack_delay) @(negedge clock);
		write_ack = 1'b1;
		do @(negedge clock); while (write_req);
		write_ack = 1'b0;
		writes_done++;
		@(negedge clock);
	endtask

	task automatic check_write(input write_cmd_t got, input vertex_job_t j);
		if (got.tag !== tag_graph_data)
			report_mismatch("write tag", got.tag, tag_graph_data);
		if (got.addr !== mem_addr_t'(j.vertex))
			report_mismatch("write address", got.addr, j.vertex);
		if (got.data !== expected_sum(j))
			report_mismatch("write sum", got.data, expected_sum(j));
	endtask

	task automatic check_totals();
		if (vertex_count !== exp_vertices)
			report_mismatch("vertex_count", vertex_count, exp_vertices);
		if (edge_count !== exp_edges)
			report_mismatch("edge_count", edge_count, exp_edges);
	endtask

	task automatic run_job(input vertex_job_t j, input int ack_delay);
		write_cmd_t got;
		cmd_addr.delete();
		cmd_tag.delete();
		fork
			send_job(j);
			collect_write(ack_delay, got);
		join
		if (cmd_addr.size() != j.degree)
			report_mismatch("read command count", cmd_addr.size(), j.degree);
		foreach (cmd_addr[i]) begin
			if (cmd_addr[i] != mem_addr_t'(j.base) + mem_addr_t'(i))
				report_mismatch("read address", cmd_addr[i], mem_addr_t'(j.base) + i);
			if (cmd_tag[i] != tag_graph_data)
				report_mismatch("read tag", cmd_tag[i], tag_graph_data);
		end
		check_write(got, j);
		exp_vertices++;
		exp_edges += j.degree;
		check_totals();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		if (job_ack !== 1'b0)
			report_mismatch("job_ack after reset", job_ack, 0);
		if (write_req !== 1'b0)
			report_mismatch("write_req after reset", write_req, 0);
		if (read_cmd.valid !== 1'b0)
			report_mismatch("read_cmd valid after reset", read_cmd.valid, 0);
		check_totals();
	endtask

	task automatic test_stall_reorder();
		random_stall = 1'b1;
		reorder      = 1'b1;
		max_delay    = 6;
		// High base so the rank sum wraps
		run_job('{vertex: 32'h0000_beef, base: 32'h7fff_fff0, degree: 32'd12}, 2);
		random_stall = 1'b0;
		reorder      = 1'b0;
	endtask

	task automatic test_job_sequence();
		vertex_job_t jobs[4];
		write_cmd_t  got;
		random_stall = 1'b1;
		max_delay    = 4;
		jobs[0] = '{vertex: 32'd10, base: 32'd300, degree: 32'd3};
		jobs[1] = '{vertex: 32'd11, base: 32'd400, degree: 32'd0};
		jobs[2] = '{vertex: 32'd12, base: 32'd410, degree: 32'd6};
		jobs[3] = '{vertex: 32'd13, base: 32'd900, degree: 32'd2};
		send_job(jobs[0]);
		// Next request waits while the current write is slow
		for (int k = 0; k < 4; k++) begin
			fork
				collect_write($urandom_range(8, 3), got);
				if (k < 3) send_job(jobs[k + 1]);
			join
			check_write(got, jobs[k]);
			exp_vertices++;
			exp_edges += jobs[k].degree;
			check_totals();
		end
		random_stall = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hce3fea02));
		rstn         = 1'b0;
		job_req      = 1'b0;
		job          = '0;
		write_ack    = 1'b0;
		exp_vertices = '0;
		exp_edges    = '0;
		repeat (2) @(negedge clock);
		rstn = 1'b1;
		test_reset_state();
		run_job('{vertex: 32'h0000_1234, base: 32'd100, degree: 32'd5}, 0);
		run_job('{vertex: 32'd77, base: 32'd500, degree: 32'd0}, 1);
		test_stall_reorder();
		inject_bad = 1'b1;
		max_delay  = 3;
		run_job('{vertex: 32'h55, base: 32'd2000, degree: 32'd4}, 1);
		inject_bad = 1'b0;
		test_job_sequence();
		// Assertion failures count as errors too
		error_count += pagerank_cu_top_inst.asserts_inst.fail_count;
		$display("Summary: %0d vertex writes checked, %0d errors", writes_done, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== tb_pagerank_cu_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// Handshake and stall assertions for the PageRank compute unit
//////////////////////////////////////////////////////////////////////

module tb_pagerank_cu_asserts import mem_pkg::*; (
	input logic       clock,
	input logic       rstn,
	input logic       job_req,
	input logic       job_ack,
	input logic       read_stall,
	input read_cmd_t  read_cmd,
	input logic       write_req,
	input write_cmd_t write_cmd
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far, read by the testbench summary
	int unsigned fail_count = 0;

	// An acknowledge always answers a request
	ack_follows_req: assert property (@(posedge clock) disable iff (!rstn)
		$rose(job_ack) |-> $past(job_req))
		else begin
			$error("job_ack rose without job_req");
			fail_count++;
		end

	// Write command held while the request is up
	write_cmd_stable: assert property (@(posedge clock) disable iff (!rstn)
		write_req |=> (!write_req || $stable(write_cmd)))
		else begin
			$error("write_cmd changed while write_req was high");
			fail_count++;
		end

	// Registered almost-full stall blocks the next cycle
	stall_blocks_read: assert property (@(posedge clock) disable iff (!rstn)
		read_stall |=> !read_cmd.valid)
		else begin
			$error("read command issued right after read_stall");
			fail_count++;
		end

endmodule

// ==== pagerank_cu_top.sv ====
//////////////////////////////////////////////////////////////////////
// PageRank vertex compute unit
// Connects control, edge counting, read issue and rank summation
//////////////////////////////////////////////////////////////////////

module pagerank_cu_top import graph_pkg::*, mem_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_req,
	input  vertex_job_t job,
	output logic        job_ack,
	output read_cmd_t   read_cmd,
	input  logic        read_stall,
	input  read_rsp_t   read_rsp,
	output logic        write_req,
	output write_cmd_t  write_cmd,
	input  logic        write_ack,
	output edge_count_t vertex_count,
	output edge_count_t edge_count
);

	logic       job_load;
	logic       fetch_en;
	logic       job_done;
	logic       issue_done;
	logic       rsp_done;
	logic       cmd_issue;
	logic       rsp_accept;
	rank_t      rank_sum;
	vertex_id_t job_vertex;

	vertex_control_fsm vertex_control_fsm_inst (
		.clock      (clock),
		.rstn       (rstn),
		.job_req    (job_req),
		.job_ack    (job_ack),
		.issue_done (issue_done),
		.rsp_done   (rsp_done),
		.write_ack  (write_ack),
		.write_req  (write_req),
		.job_load   (job_load),
		.fetch_en   (fetch_en),
		.job_done   (job_done)
	);

	edge_counter edge_counter_inst (
		.clock        (clock),
		.rstn         (rstn),
		.job_load     (job_load),
		.job          (job),
		.fetch_en     (fetch_en),
		.cmd_issue    (cmd_issue),
		.rsp_accept   (rsp_accept),
		.job_done     (job_done),
		.issue_done   (issue_done),
		.rsp_done     (rsp_done),
		.vertex_count (vertex_count),
		.edge_count   (edge_count)
	);

	read_command_gen read_command_gen_inst (
		.clock      (clock),
		.rstn       (rstn),
		.job_load   (job_load),
		.job        (job),
		.fetch_en   (fetch_en),
		.issue_done (issue_done),
		.read_stall (read_stall),
		.read_cmd   (read_cmd),
		.cmd_issue  (cmd_issue),
		.job_vertex (job_vertex)
	);

	rank_sum_accum rank_sum_accum_inst (
		.clock      (clock),
		.rstn       (rstn),
		.job_load   (job_load),
		.read_rsp   (read_rsp),
		.rsp_accept (rsp_accept),
		.rank_sum   (rank_sum)
	);

	// Result write goes to the vertex's own slot
	assign write_cmd.tag  = tag_graph_data;
	assign write_cmd.addr = mem_addr_t'(job_vertex);
	assign write_cmd.data = mem_data_t'(rank_sum);

endmodule

// ==== rank_sum_accum.sv ====
//////////////////////////////////////////////////////////////////////
// Rank sum accumulator
// Routes read responses by structure tag and sums graph-data ranks
//////////////////////////////////////////////////////////////////////

module rank_sum_accum import graph_pkg::*, mem_pkg::*; (
	input  logic      clock,
	input  logic      rstn,
	input  logic      job_load,
	input  read_rsp_t read_rsp,
	output logic      rsp_accept,
	output rank_t     rank_sum
);

	//////////////////////////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rsp_accept = 1'b0;
		if (read_rsp.valid) begin
			case (read_rsp.tag)
				tag_graph_data: begin
					rsp_accept = 1'b1;
				end
				// Edge array and anything else never reach the sum
				tag_edge_array, tag_other: begin
					rsp_accept = 1'b0;
				end
				default: begin
					rsp_accept = 1'b0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Accumulation
	//////////////////////////////////////////////////////////////////////

	// Wraps at rank width
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rank_sum <= '0;
		end else if (job_load) begin
			rank_sum <= '0;
		end else if (rsp_accept) begin
			rank_sum <= rank_sum + rank_t'(read_rsp.data);
		end
	end

endmodule

// ==== read_command_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Read command generator
// Issues one graph-data read per edge, walking up from the base index
//////////////////////////////////////////////////////////////////////

module read_command_gen import graph_pkg::*, mem_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_load,
	input  vertex_job_t job,
	input  logic        fetch_en,
	input  logic        issue_done,
	input  logic        read_stall,
	output read_cmd_t   read_cmd,
	output logic        cmd_issue,
	output vertex_id_t  job_vertex
);

	logic        stall_q;
	edge_index_t edge_idx;

	// Almost-full stall takes effect one cycle late
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stall_q <= 1'b0;
		end else begin
			stall_q <= read_stall;
		end
	end

	assign cmd_issue = fetch_en && !issue_done && !stall_q;

	// Job copy and running edge index
	always_ff @(posedge clock) begin
		if (job_load) begin
			edge_idx   <= job.base;
			job_vertex <= job.vertex;
		end else if (cmd_issue) begin
			edge_idx <= edge_idx + 1'b1;
		end
	end

	always_comb begin
		read_cmd.valid = cmd_issue;
		read_cmd.tag   = tag_graph_data;
		read_cmd.addr  = mem_addr_t'(edge_idx);
	end

endmodule

// ==== edge_counter.sv ====
//////////////////////////////////////////////////////////////////////
// Edge counter
// Tracks issued and returned edges of the current job and keeps
// the running vertex and edge totals
//////////////////////////////////////////////////////////////////////

module edge_counter import graph_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_load,
	input  vertex_job_t job,
	input  logic        fetch_en,
	input  logic        cmd_issue,
	input  logic        rsp_accept,
	input  logic        job_done,
	output logic        issue_done,
	output logic        rsp_done,
	output edge_count_t vertex_count,
	output edge_count_t edge_count
);

	edge_count_t degree_q;
	edge_count_t issued_q;
	edge_count_t returned_q;

	// Per-job counts, cleared when a new job is latched
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_q   <= '0;
			issued_q   <= '0;
			returned_q <= '0;
		end else if (job_load) begin
			degree_q   <= job.degree;
			issued_q   <= '0;
			returned_q <= '0;
		end else begin
			if (fetch_en && cmd_issue) begin
				issued_q <= issued_q + 1'b1;
			end
			if (rsp_accept) begin
				returned_q <= returned_q + 1'b1;
			end
		end
	end

	assign issue_done = (issued_q == degree_q);
	assign rsp_done   = (returned_q == degree_q);

	// Totals grow once per finished write handshake
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count <= '0;
			edge_count   <= '0;
		end else if (job_done) begin
			vertex_count <= vertex_count + 1'b1;
			edge_count   <= edge_count + degree_q;
		end
	end

endmodule

// ==== vertex_control_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Vertex control FSM
// Runs job intake, edge fetch, completion wait and the write
// handshake for one vertex at a time
//////////////////////////////////////////////////////////////////////

module vertex_control_fsm import graph_pkg::*; (
	input  logic clock,
	input  logic rstn,
	input  logic job_req,
	output logic job_ack,
	input  logic issue_done,
	input  logic rsp_done,
	input  logic write_ack,
	output logic write_req,
	output logic job_load,
	output logic fetch_en,
	output logic job_done
);

	cu_state_t state_q;
	cu_state_t state_d;

	//////////////////////////////////////////////////////////////////////
	// Job intake
	//////////////////////////////////////////////////////////////////////

	// Only take a job in idle, and never twice on one request
	assign job_load = (state_q == cu_idle) && job_req && !job_ack;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ack <= 1'b0;
		end else if (job_load) begin
			job_ack <= 1'b1;
		end else if (!job_req) begin
			job_ack <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// State sequencing
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			cu_idle: begin
				if (job_load) begin
					state_d = cu_fetch;
				end
			end
			cu_fetch: begin
				if (issue_done) begin
					state_d = cu_drain;
				end
			end
			cu_drain: begin
				// All accepted ranks already sit in the sum here
				if (rsp_done) begin
					state_d = cu_write_req;
				end
			end
			cu_write_req: begin
				if (write_ack) begin
					state_d = cu_write_release;
				end
			end
			cu_write_release: begin
				if (!write_ack) begin
					state_d = cu_idle;
				end
			end
			default: begin
				state_d = cu_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state_q <= cu_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// Decoded outputs
	assign fetch_en  = (state_q == cu_fetch);
	assign write_req = (state_q == cu_write_req);
	assign job_done  = (state_q == cu_write_release) && !write_ack;

endmodule

// ==== mem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Memory interface types for the PageRank compute unit
// Addresses, structure tags and the read and write command formats
//////////////////////////////////////////////////////////////////////

`include "cu_config.svh"

package mem_pkg;

	typedef logic [`CU_ADDR_W-1:0] mem_addr_t;
	typedef logic [`CU_RANK_W-1:0] mem_data_t;

	// Which structure a command or response belongs to
	typedef enum logic [1:0] {
		tag_graph_data,
		tag_edge_array,
		tag_other
	} struct_tag_t;

	// Read command, edge index sits in the low address bits
	typedef struct packed {
		logic        valid;
		struct_tag_t tag;
		mem_addr_t   addr;
	} read_cmd_t;

	// Read response carrying one rank contribution
	typedef struct packed {
		logic        valid;
		struct_tag_t tag;
		mem_data_t   data;
	} read_rsp_t;

	// Write command, qualified by the write handshake
	typedef struct packed {
		struct_tag_t tag;
		mem_addr_t   addr;
		mem_data_t   data;
	} write_cmd_t;

endpackage

// ==== graph_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Graph types for the PageRank compute unit
// Vertex, edge and rank fields, the vertex job and the control states
//////////////////////////////////////////////////////////////////////

`include "cu_config.svh"

package graph_pkg;

	typedef logic [`CU_VERTEX_W-1:0] vertex_id_t;
	typedef logic [`CU_EDGE_W-1:0]   edge_index_t;
	typedef logic [`CU_EDGE_W-1:0]   edge_count_t;
	typedef logic [`CU_RANK_W-1:0]   rank_t;

	// One vertex job, base indexes the in-neighbour rank array
	typedef struct packed {
		vertex_id_t  vertex;
		edge_index_t base;
		edge_count_t degree;
	} vertex_job_t;

	// Control unit states
	typedef enum logic [2:0] {
		cu_idle,
		cu_fetch,
		cu_drain,
		cu_write_req,
		cu_write_release
	} cu_state_t;

endpackage

// ==== cu_config.svh ====
//////////////////////////////////////////////////////////////////////
// PageRank compute unit configuration
// Field widths shared by the graph and memory type packages
//////////////////////////////////////////////////////////////////////

`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Vertex id width
`define CU_VERTEX_W 32

// Edge index and edge count width
`define CU_EDGE_W 32

// Rank value width, sums wrap at this size
`define CU_RANK_W 32

// Memory address width
`define CU_ADDR_W 64

`endif
